// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/10ps
TOP       := tb_video_playfield
FILELIST  := project.f

BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== project.f ====
source/playfield_pkg.sv
source/pf_fetch_ctrl.sv
source/pf_line_addr.sv
source/pf_pixel_expand.sv
source/pf_scanout.sv
source/video_playfield.sv
sim/tb_video_playfield.sv

// ==== sim/tb_video_playfield.sv ====
//##################################################
// video playfield testbench
// vram model, line timing, reference pixel model
// and a comparing process on the colour output
//##################################################

`default_nettype none
`timescale 1ns/10ps

module tb_video_playfield;

    localparam int          LINE_COUNTS = 256;          // h counts per line
    localparam int          FETCH_END   = 240;          // mem_fetch_i low from here
    localparam int          VID_LEFT    = 16;
    localparam int          VID_RIGHT   = 80;
    // output follows the window from the cycle after the start count to the end count
    localparam int          WIN_FIRST   = playfield_pkg::H_SCANOUT_BEGIN + VID_LEFT + 1;
    localparam int          WIN_LAST    = playfield_pkg::H_SCANOUT_BEGIN + VID_RIGHT;
    localparam int          MAX_CYCLES  = 12000;        // whole run needs about 7700
    localparam logic [31:0] LFSR_SEED   = 32'hfeec_e541;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

    logic                       clk;
    logic                       reset_i;
    playfield_pkg::pf_ctrl_t    pf_ctrl_i;
    logic                       mem_fetch_i;
    logic                       mem_fetch_start_i;
    playfield_pkg::hres_t       h_count_i;
    logic                       h_line_last_pixel_i;
    logic                       last_frame_pixel_i;
    playfield_pkg::color_t      border_color_i;
    playfield_pkg::hres_t       vid_left_i;
    playfield_pkg::hres_t       vid_right_i;
    logic                       vram_sel_o;
    playfield_pkg::addr_t       vram_addr_o;
    playfield_pkg::word_t       vram_data_i;
    playfield_pkg::color_t      pf_color_index_o;

    logic   check_en;                           // compare output on this line
    int     line_y;                             // display line within frame
    int     strobes;                            // reads issued on this line
    int     checks;
    int     errors;
    int     tests;
    string  test_name;

    video_playfield video_playfield_i (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // vram contents, one lfsr step per data bit, every address bit mixed in
    function automatic playfield_pkg::word_t vram_word(input playfield_pkg::addr_t addr);
        logic [31:0]            s;
        playfield_pkg::word_t   w;
        s = LFSR_SEED ^ {addr, addr};
        w = '0;
        for (int i = 0; i < 16; i++) begin
            s = lfsr_step(s);
            w = {w[14:0], s[0]};
        end
        return w;
    endfunction

    function automatic playfield_pkg::addr_t line_start_of(input int y);
        int lines;
        lines = y / (int'(pf_ctrl_i.v_repeat) + 1);     // display lines already shown
        if (pf_ctrl_i.blank) begin
            return pf_ctrl_i.start_addr;                // held at top while blanked
        end
        return pf_ctrl_i.start_addr + playfield_pkg::addr_t'(lines * int'(pf_ctrl_i.line_len));
    endfunction

    // output index in window cycle x of line y
    function automatic playfield_pkg::color_t expected_pixel(input int x, input int y);
        int                     px;
        int                     grp;
        int                     col;
        playfield_pkg::addr_t   base;
        playfield_pkg::word_t   w;
        playfield_pkg::color_t  idx;
        px   = x / (int'(pf_ctrl_i.h_repeat) + 1);
        grp  = px / 8;
        col  = px % 8;
        base = line_start_of(y);
        case (pf_ctrl_i.bpp)
            playfield_pkg::BPP_1_ATTR: begin
                w   = vram_word(base + playfield_pkg::addr_t'(grp));
                idx = {4'h0, w[7 - col] ? w[15:12] : w[11:8]};     // fore or back nibble
            end
            playfield_pkg::BPP_4: begin
                w   = vram_word(base + playfield_pkg::addr_t'(2 * grp + col / 4));
                idx = {4'h0, w[15 - 4 * (col % 4) -: 4]};
            end
            default: begin
                w   = vram_word(base + playfield_pkg::addr_t'(4 * grp + col / 2));
                idx = (col % 2 == 0) ? w[15:8] : w[7:0];
            end
        endcase
        return idx ^ pf_ctrl_i.colorbase;
    endfunction

    task automatic check_equal(input logic [15:0] expected, input logic [15:0] actual,
                               input string what);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("[ERROR] %s: %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // one line of video timing
    task automatic drive_line(input int y, input logic frame_end);
        int c;
        for (c = 0; c < LINE_COUNTS; c++) begin
            @(posedge clk);
            #2;
            line_y              = y;
            h_count_i           = playfield_pkg::hres_t'(c);
            mem_fetch_start_i   = (c == 0);
            mem_fetch_i         = (c < FETCH_END);
            h_line_last_pixel_i = (c == LINE_COUNTS - 1);
            last_frame_pixel_i  = frame_end && (c == LINE_COUNTS - 1);
        end
    endtask

    task automatic run_test(input string name, input playfield_pkg::bpp_t bpp,
                            input playfield_pkg::rep_t h_rep, input playfield_pkg::rep_t v_rep,
                            input logic blank, input int lines);
        int errors_before;
        errors_before        = errors;
        test_name            = name;
        pf_ctrl_i.blank      = blank;
        pf_ctrl_i.start_addr = playfield_pkg::addr_t'(16'h0123 + tests * 16'h0400);
        pf_ctrl_i.line_len   = 16'd20;
        pf_ctrl_i.colorbase  = 8'h3c ^ playfield_pkg::color_t'(tests * 8'h11);
        pf_ctrl_i.bpp        = bpp;
        pf_ctrl_i.h_repeat   = h_rep;
        pf_ctrl_i.v_repeat   = v_rep;
        check_en             = 1'b0;
        drive_line(0, 1'b1);                            // ends the previous frame
        check_en             = 1'b1;
        for (int y = 0; y < lines; y++) begin
            drive_line(y, 1'b0);
            assert (strobes > 0) else begin
                errors++;
                $display("%s: line %0d made no VRAM read", name, y);
            end
        end
        check_en = 1'b0;
        tests++;
        $display("test %s done, %0d errors", name, errors - errors_before);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // data comes back in the cycle after a strobe
    initial begin : vram_model
        logic                   sel;
        playfield_pkg::addr_t   addr;
        vram_data_i = '0;
        forever begin
            @(negedge clk);
            sel  = vram_sel_o;
            addr = vram_addr_o;
            @(posedge clk);
            #2;
            vram_data_i = sel ? vram_word(addr) : '0;
        end
    end

    always @(negedge clk) begin : compare
        int                     x;
        playfield_pkg::color_t  want;
        x = int'(h_count_i) - WIN_FIRST;
        if (mem_fetch_start_i) begin
            strobes = 0;                                // new line, count reads from here
        end
        if (check_en) begin
            if (int'(h_count_i) >= WIN_FIRST && int'(h_count_i) <= WIN_LAST) begin
                want = expected_pixel(x, line_y);
            end else begin
                want = border_color_i ^ pf_ctrl_i.colorbase;
            end
            check_equal(16'(want), 16'(pf_color_index_o),
                        $sformatf("pixel line %0d count %0d", line_y, h_count_i));
            if (vram_sel_o) begin
                check_equal(line_start_of(line_y) + playfield_pkg::addr_t'(strobes), vram_addr_o,
                            $sformatf("read %0d address line %0d", strobes, line_y));
            end
        end
        if (vram_sel_o) begin
            strobes++;
        end
    end

    initial begin : watchdog
        for (int i = 0; i < MAX_CYCLES; i++) begin
            @(posedge clk);
        end
        $display("run did not finish within %0d cycles", MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        reset_i             = 1'b1;
        pf_ctrl_i           = '0;
        pf_ctrl_i.colorbase = 8'h3c;
        mem_fetch_i         = 1'b0;
        mem_fetch_start_i   = 1'b0;
        h_count_i           = '0;
        h_line_last_pixel_i = 1'b0;
        last_frame_pixel_i  = 1'b0;
        border_color_i      = 8'h5a;
        vid_left_i          = playfield_pkg::hres_t'(VID_LEFT);
        vid_right_i         = playfield_pkg::hres_t'(VID_RIGHT);
        check_en            = 1'b0;
        line_y              = 0;
        strobes             = 0;
        checks              = 0;
        errors              = 0;
        tests               = 0;
        test_name           = "reset";
        repeat (10) @(posedge clk);
        #2;
        reset_i = 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_equal(16'h0, 16'(vram_sel_o), "vram strobe");
            check_equal(16'(border_color_i ^ pf_ctrl_i.colorbase), 16'(pf_color_index_o),
                        "idle output");
        end
        tests++;
        $display("test reset done, %0d errors", errors);
        @(posedge clk);
        #2;
        run_test("bpp1", playfield_pkg::BPP_1_ATTR, 2'd0, 2'd0, 1'b0, 4);
        run_test("bpp4", playfield_pkg::BPP_4, 2'd0, 2'd0, 1'b0, 4);
        run_test("bpp8", playfield_pkg::BPP_8, 2'd0, 2'd0, 1'b0, 4);
        run_test("hrep2", playfield_pkg::BPP_4, 2'd2, 2'd0, 1'b0, 3);
        run_test("vrep1", playfield_pkg::BPP_8, 2'd0, 2'd1, 1'b0, 6);
        run_test("blank", playfield_pkg::BPP_8, 2'd0, 2'd0, 1'b1, 3);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/pf_fetch_ctrl.sv ====
//##################################################
// playfield fetch control
// FSM that strobes vram reads for each 8 pixel
// group and collects the returned words
//##################################################

`default_nettype none
`timescale 1ns/10ps

module pf_fetch_ctrl (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire playfield_pkg::bpp_t            bpp_i,
    input  wire logic                           mem_fetch_i,
    input  wire logic                           mem_fetch_start_i,
    input  wire playfield_pkg::addr_t           line_start_i,
    input  wire logic                           buf_full_i,
    output      logic                           vram_sel_o,
    output      playfield_pkg::addr_t           vram_addr_o,
    input  wire playfield_pkg::word_t           vram_data_i,
    output      logic                           words_ready_o,
    output      playfield_pkg::fetch_words_t    words_o
);

    typedef enum logic [2:0] {
        FETCH_IDLE,                             // waiting for fetch window
        FETCH_ADDR,                             // strobe word 0 once buffer has room
        FETCH_WAIT,                             // strobe word 1, word 0 in flight
        FETCH_READ_0,                           // capture word 0, strobe word 2
        FETCH_READ_1,                           // capture word 1, strobe word 3
        FETCH_READ_2,                           // capture word 2
        FETCH_READ_3                            // capture word 3
    } fetch_st_t;

    fetch_st_t                      state, state_next;
    playfield_pkg::addr_t           disp_addr, disp_addr_next;   // next display word to read
    playfield_pkg::fetch_words_t    words_next;
    logic [2:0]                     group_words;                 // words in one group
    logic                           issue;                       // strobe a read this cycle
    logic                           initial_grp, initial_next;   // first group of the line
    logic                           ready_next;

    always_comb begin
        case (bpp_i)
            playfield_pkg::BPP_1_ATTR: group_words = 3'(playfield_pkg::WORDS_1BPP);
            playfield_pkg::BPP_4:      group_words = 3'(playfield_pkg::WORDS_4BPP);
            default:                   group_words = 3'(playfield_pkg::WORDS_8BPP);
        endcase
    end

    always_comb begin
        state_next   = state;
        issue        = 1'b0;
        ready_next   = 1'b0;
        initial_next = initial_grp;
        words_next   = words_o;

        if (!mem_fetch_i) begin
            state_next = FETCH_IDLE;                        // window closed, stop
        end else begin
            case (state)
                FETCH_IDLE: begin
                    state_next = FETCH_ADDR;
                end
                FETCH_ADDR: begin
                    if (!buf_full_i) begin
                        issue        = 1'b1;                // word 0
                        ready_next   = !initial_grp;        // hand over previous group
                        initial_next = 1'b0;
                        state_next   = FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    issue      = group_words > 3'(playfield_pkg::WORDS_1BPP);  // word 1
                    state_next = FETCH_READ_0;
                end
                FETCH_READ_0: begin
                    words_next.w0 = vram_data_i;
                    if (group_words == 3'(playfield_pkg::WORDS_1BPP)) begin
                        state_next = FETCH_ADDR;            // 1 bpp group done
                    end else begin
                        issue      = group_words > 3'(playfield_pkg::WORDS_4BPP);  // word 2
                        state_next = FETCH_READ_1;
                    end
                end
                FETCH_READ_1: begin
                    words_next.w1 = vram_data_i;
                    if (group_words == 3'(playfield_pkg::WORDS_4BPP)) begin
                        state_next = FETCH_ADDR;            // 4 bpp group done
                    end else begin
                        issue      = 1'b1;                  // word 3
                        state_next = FETCH_READ_2;
                    end
                end
                FETCH_READ_2: begin
                    words_next.w2 = vram_data_i;
                    state_next    = FETCH_READ_3;
                end
                FETCH_READ_3: begin
                    words_next.w3 = vram_data_i;
                    state_next    = FETCH_ADDR;             // 8 bpp group done
                end
                default: begin
                    state_next = FETCH_IDLE;
                end
            endcase
        end

        disp_addr_next = issue ? disp_addr + 1'b1 : disp_addr;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= FETCH_IDLE;
            vram_sel_o    <= 1'b0;
            words_ready_o <= 1'b0;
            initial_grp   <= 1'b0;
        end else begin
            state         <= state_next;
            vram_sel_o    <= issue;                         // registered strobe
            words_ready_o <= ready_next;
            initial_grp   <= initial_next;
            if (mem_fetch_start_i) begin
                initial_grp <= 1'b1;                        // new line, nothing to hand over yet
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            vram_addr_o <= disp_addr;                       // registered address
        end
        words_o   <= words_next;
        disp_addr <= mem_fetch_start_i ? line_start_i : disp_addr_next;
    end

    // every strobe was decided inside the fetch window
    a_sel_in_window: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> $past(mem_fetch_i));

endmodule

`default_nettype wire

// ==== source/pf_line_addr.sv ====
//##################################################
// playfield line addressing
// line start address and vertical repeat count,
// advanced per line and reloaded per frame
//##################################################

`default_nettype none
`timescale 1ns/10ps

module pf_line_addr (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   blank_i,
    input  wire playfield_pkg::addr_t   start_addr_i,
    input  wire playfield_pkg::word_t   line_len_i,
    input  wire playfield_pkg::rep_t    v_repeat_i,
    input  wire logic                   h_line_last_pixel_i,
    input  wire logic                   last_frame_pixel_i,
    output      playfield_pkg::addr_t   line_start_o
);

    playfield_pkg::rep_t v_count;               // lines left before advancing

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_start_o <= '0;
            v_count      <= '0;
        end else if (blank_i || last_frame_pixel_i) begin
            line_start_o <= start_addr_i;       // back to top of bitmap
            v_count      <= v_repeat_i;
        end else if (h_line_last_pixel_i) begin
            if (v_count != '0) begin
                v_count <= v_count - 1'b1;      // same data again next line
            end else begin
                v_count      <= v_repeat_i;
                line_start_o <= line_start_o + line_len_i;  // step to next display line
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/pf_pixel_expand.sv ====
//##################################################
// playfield pixel expansion
// turns fetched words into eight colour indices
// by depth and keeps the buffer full flag
//##################################################

`default_nettype none
`timescale 1ns/10ps

module pf_pixel_expand (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire playfield_pkg::bpp_t            bpp_i,
    input  wire logic                           words_ready_i,
    input  wire playfield_pkg::fetch_words_t    words_i,
    input  wire logic                           buf_take_i,
    input  wire logic                           mem_fetch_start_i,
    output      logic                           buf_full_o,
    output      playfield_pkg::pixels_t         pixels_buf_o
);

    playfield_pkg::pixels_t     pixels;         // expanded group
    playfield_pkg::attr_word_u  attr_word;      // w0 seen as attribute word
    logic [31:0]                nibbles;        // w0 then w1 for 4 bpp

    always_comb begin
        attr_word = words_i.w0;
        nibbles   = {words_i.w0, words_i.w1};
        case (bpp_i)
            playfield_pkg::BPP_1_ATTR: begin
                for (int i = 0; i < 8; i++) begin
                    pixels[i] = {4'h0, attr_word.attr.pix[i] ?
                                 attr_word.attr.fore : attr_word.attr.back};
                end
            end
            playfield_pkg::BPP_4: begin
                for (int i = 0; i < 8; i++) begin
                    pixels[7-i] = {4'h0, nibbles[31-4*i -: 4]};  // leftmost nibble first
                end
            end
            default: begin
                pixels = playfield_pkg::pixels_t'(words_i);      // bytes already in order
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            buf_full_o <= 1'b0;
        end else if (mem_fetch_start_i) begin
            buf_full_o <= 1'b0;                 // new line, drop leftovers
        end else if (words_ready_i) begin
            buf_full_o <= 1'b1;                 // refill wins over a take
        end else if (buf_take_i) begin
            buf_full_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (words_ready_i) begin
            pixels_buf_o <= pixels;
        end
    end

    // fetch side waits for room, so a full buffer is never overwritten
    a_no_overrun: assert property (@(posedge clk) disable iff (reset_i)
        words_ready_i |-> (!buf_full_o || buf_take_i));

endmodule

`default_nettype wire

// ==== source/pf_scanout.sv ====
//##################################################
// playfield scanout
// visible window, horizontal repeat and pixel
// shift register with colour base and border
//##################################################

`default_nettype none
`timescale 1ns/10ps

module pf_scanout (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire playfield_pkg::rep_t        h_repeat_i,
    input  wire playfield_pkg::color_t      colorbase_i,
    input  wire playfield_pkg::color_t      border_color_i,
    input  wire playfield_pkg::hres_t       h_count_i,
    input  wire playfield_pkg::hres_t       vid_left_i,
    input  wire playfield_pkg::hres_t       vid_right_i,
    input  wire logic                       mem_fetch_i,
    input  wire logic                       mem_fetch_start_i,
    input  wire logic                       h_line_last_pixel_i,
    input  wire playfield_pkg::pixels_t     pixels_buf_i,
    output      logic                       buf_take_o,
    output      playfield_pkg::color_t      pf_color_index_o
);

    playfield_pkg::hres_t   start_hcount;       // h count that opens the window
    playfield_pkg::hres_t   end_hcount;         // h count that closes it
    logic                   scanout;            // window active
    logic                   scanout_start;
    logic                   scanout_end;
    logic                   group_end;          // last cycle of the eighth column
    playfield_pkg::rep_t    h_cnt;              // repeat cycles left for this pixel
    logic [2:0]             col;                // pixel column within group
    playfield_pkg::pixels_t pixels;             // shifting pixels, top byte shown

    assign scanout_start = (h_count_i == start_hcount) && mem_fetch_i;
    assign scanout_end   = (h_count_i == end_hcount);
    assign group_end     = scanout && (h_cnt == '0) &&
                           (col == 3'(playfield_pkg::PIXELS_PER_GROUP - 1));
    assign buf_take_o    = scanout_start || group_end;

    assign pf_color_index_o = (scanout ? pixels[7] : border_color_i) ^ colorbase_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scanout      <= 1'b0;
            start_hcount <= '1;                 // out of reach until first line start
            end_hcount   <= '1;
            h_cnt        <= '0;
            col          <= '0;
        end else begin
            if (mem_fetch_start_i) begin
                start_hcount <= playfield_pkg::hres_t'(playfield_pkg::H_SCANOUT_BEGIN)
                                + vid_left_i;
                end_hcount   <= playfield_pkg::hres_t'(playfield_pkg::H_SCANOUT_BEGIN)
                                + vid_right_i;
            end
            if (scanout) begin
                if (h_cnt != '0) begin
                    h_cnt <= h_cnt - 1'b1;      // hold current pixel
                end else begin
                    h_cnt <= h_repeat_i;
                    col   <= col + 1'b1;        // wraps after eighth column
                end
            end
            if (scanout_start) begin
                scanout <= 1'b1;
                h_cnt   <= h_repeat_i;
                col     <= '0;
            end
            if (scanout_end) begin
                scanout <= 1'b0;                // border from here on
            end
        end
    end

    always_ff @(posedge clk) begin
        if (buf_take_o) begin
            pixels <= pixels_buf_i;             // next 8 pixels from buffer
        end else if (scanout && h_cnt == '0) begin
            pixels <= {pixels[6:0], border_color_i};  // next pixel, border fills in
        end
    end

    // a line never carries its window into the next one
    a_window_closed: assert property (@(posedge clk) disable iff (reset_i)
        h_line_last_pixel_i |=> !scanout);

endmodule

`default_nettype wire

// ==== source/playfield_pkg.sv ====
//##################################################
// playfield package
// shared widths, types, depth codes and timing
// constants for the bitmap playfield generator
//##################################################

`default_nettype none

package playfield_pkg;

    typedef logic [15:0] word_t;                // vram data word
    typedef logic [15:0] addr_t;                // vram word address
    typedef logic [7:0]  color_t;               // colour index
    typedef logic [10:0] hres_t;                // horizontal pixel count
    typedef logic [1:0]  rep_t;                 // pixel repeat 0-3

    typedef enum logic [1:0] {
        BPP_1_ATTR = 2'd0,                      // 1 bpp, fore/back attribute per word
        BPP_4      = 2'd1,                      // 4 bpp, 4 pixels per word
        BPP_8      = 2'd2                       // 8 bpp, 2 pixels per word (code 3 alike)
    } bpp_t;

    // index 7 is the leftmost pixel, in the top byte
    typedef color_t [7:0] pixels_t;

    // 1 bpp display word, seen raw or split into attribute and pixel bits
    typedef union packed {
        word_t raw;
        struct packed {
            logic [3:0] fore;                   // colour for set pixel bits
            logic [3:0] back;                   // colour for clear pixel bits
            logic [7:0] pix;                    // bit 7 leftmost
        } attr;
    } attr_word_u;

    typedef struct packed {
        logic   blank;                          // playfield off, hold at start address
        addr_t  start_addr;                     // first display word of the frame
        word_t  line_len;                       // words added per display line
        color_t colorbase;                      // XORed onto every output index
        bpp_t   bpp;                            // bitmap depth
        rep_t   h_repeat;                       // extra cycles per pixel
        rep_t   v_repeat;                       // extra lines per display line
    } pf_ctrl_t;

    typedef struct packed {
        word_t w0;                              // first word, top bits
        word_t w1;
        word_t w2;
        word_t w3;
    } fetch_words_t;

    localparam int OFFSCREEN_WIDTH  = 16;                   // h count before visible area
    localparam int H_SCANOUT_BEGIN  = OFFSCREEN_WIDTH - 2;  // scanout lead for fetch pipeline
    localparam int PIXELS_PER_GROUP = 8;                    // pixels per fetch group

    localparam int WORDS_1BPP = 1;                          // words per group at each depth
    localparam int WORDS_4BPP = 2;
    localparam int WORDS_8BPP = 4;

endpackage

`default_nettype wire

// ==== source/video_playfield.sv ====
//##################################################
// video playfield
// bitmap playfield generator, fetch control, line
// addressing, pixel expansion and scanout
//##################################################

`default_nettype none
`timescale 1ns/10ps

module video_playfield (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire playfield_pkg::pf_ctrl_t    pf_ctrl_i,
    input  wire logic                       mem_fetch_i,
    input  wire logic                       mem_fetch_start_i,
    input  wire playfield_pkg::hres_t       h_count_i,
    input  wire logic                       h_line_last_pixel_i,
    input  wire logic                       last_frame_pixel_i,
    input  wire playfield_pkg::color_t      border_color_i,
    input  wire playfield_pkg::hres_t       vid_left_i,
    input  wire playfield_pkg::hres_t       vid_right_i,
    output      logic                       vram_sel_o,
    output      playfield_pkg::addr_t       vram_addr_o,
    input  wire playfield_pkg::word_t       vram_data_i,
    output      playfield_pkg::color_t      pf_color_index_o
);

    playfield_pkg::addr_t           line_start;     // current line start address
    logic                           buf_full;       // pixel buffer holds a group
    logic                           buf_take;       // scanout loads the buffer
    logic                           words_ready;    // fetched group handed over
    playfield_pkg::fetch_words_t    words;
    playfield_pkg::pixels_t         pixels_buf;

    pf_fetch_ctrl fetch_i (
        .clk(clk), .reset_i(reset_i), .bpp_i(pf_ctrl_i.bpp),
        .mem_fetch_i(mem_fetch_i), .mem_fetch_start_i(mem_fetch_start_i),
        .line_start_i(line_start), .buf_full_i(buf_full),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .words_ready_o(words_ready), .words_o(words)
    );

    pf_line_addr line_addr_i (
        .clk(clk), .reset_i(reset_i), .blank_i(pf_ctrl_i.blank),
        .start_addr_i(pf_ctrl_i.start_addr), .line_len_i(pf_ctrl_i.line_len),
        .v_repeat_i(pf_ctrl_i.v_repeat), .h_line_last_pixel_i(h_line_last_pixel_i),
        .last_frame_pixel_i(last_frame_pixel_i), .line_start_o(line_start)
    );

    pf_pixel_expand expand_i (
        .clk(clk), .reset_i(reset_i), .bpp_i(pf_ctrl_i.bpp),
        .words_ready_i(words_ready), .words_i(words), .buf_take_i(buf_take),
        .mem_fetch_start_i(mem_fetch_start_i), .buf_full_o(buf_full),
        .pixels_buf_o(pixels_buf)
    );

    pf_scanout scanout_i (
        .clk(clk), .reset_i(reset_i), .h_repeat_i(pf_ctrl_i.h_repeat),
        .colorbase_i(pf_ctrl_i.colorbase), .border_color_i(border_color_i),
        .h_count_i(h_count_i), .vid_left_i(vid_left_i), .vid_right_i(vid_right_i),
        .mem_fetch_i(mem_fetch_i), .mem_fetch_start_i(mem_fetch_start_i),
        .h_line_last_pixel_i(h_line_last_pixel_i), .pixels_buf_i(pixels_buf),
        .buf_take_o(buf_take), .pf_color_index_o(pf_color_index_o)
    );

endmodule

`default_nettype wire
